/* aes_key_expand_top.f */
source/aes_key_pkg.sv
source/aes_key_word_select.sv
source/aes_sbox_lut.sv
source/aes_key_word_combine.sv
source/aes_key_expand_top.sv
test/aes_key_expand_checker.sv
test/tb_aes_key_expand.sv

/* source/aes_key_expand_top.sv */
////////////////////
// AES round-key expansion for AES-128 and AES-256
// Feed every key_o back as the next key_i
// Pulse clear_i once before the first round of a schedule
////////////////////

`timescale 1ns/1ns

module aes_key_expand_top #(
  parameter bit AES256Enable = 1'b1
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  clear_i,
  input  logic                  en_i,
  input  logic                  out_ack_i,
  input  aes_key_pkg::ciph_op_e op_i,
  input  aes_key_pkg::key_len_e key_len_i,
  input  aes_key_pkg::round_t   round_i,
  input  aes_key_pkg::key_t     key_i,
  output aes_key_pkg::key_t     key_o,
  output logic                  out_req_o
);

  aes_key_pkg::word_t sub_word_in;
  aes_key_pkg::word_t sub_word_out;
  logic         [3:0] sbox_req;

  // SubWord input with RotWord applied
  aes_key_word_select #(
    .AES256Enable ( AES256Enable )
  ) u_word_select (
    .key_len_i  ( key_len_i   ),
    .op_i       ( op_i        ),
    .round_i    ( round_i     ),
    .key_i      ( key_i       ),
    .sub_word_o ( sub_word_in )
  );

  // One S-box per byte of the word
  for (genvar i = 0; i < 4; i++) begin : gen_sbox
    aes_sbox_lut u_sbox (
      .clk_i     ( clk_i           ),
      .rst_ni    ( rst_ni          ),
      .en_i      ( en_i            ),
      .out_ack_i ( out_ack_i       ),
      .data_i    ( sub_word_in[i]  ),
      .data_o    ( sub_word_out[i] ),
      .out_req_o ( sbox_req[i]     )
    );
  end

  // Rcon and new key words
  aes_key_word_combine #(
    .AES256Enable ( AES256Enable )
  ) u_word_combine (
    .clk_i      ( clk_i        ),
    .rst_ni     ( rst_ni       ),
    .clear_i    ( clear_i      ),
    .op_i       ( op_i         ),
    .key_len_i  ( key_len_i    ),
    .round_i    ( round_i      ),
    .key_i      ( key_i        ),
    .sub_word_i ( sub_word_out ),
    .sbox_req_i ( sbox_req     ),
    .out_ack_i  ( out_ack_i    ),
    .key_o      ( key_o        ),
    .out_req_o  ( out_req_o    )
  );

endmodule

/* source/aes_key_pkg.sv */
////////////////////
// Types, constants and GF(2^8) helpers shared by the key expansion blocks
// Only AES-128 and AES-256 key lengths are encoded
// Byte 0 of a word and word 0 of a key sit in the low bits
////////////////////

package aes_key_pkg;

  // One state byte
  typedef logic [7:0] byte_t;

  // Key word made of four bytes
  typedef byte_t [3:0] word_t;

  // Full key register contents
  // AES-128 only uses words 3 to 0
  typedef word_t [7:0] key_t;

  // Round counter
  typedef logic [3:0] round_t;

  typedef enum logic [1:0] {
    AES_128 = 2'b01,
    AES_256 = 2'b10
  } key_len_e;

  typedef enum logic {
    CIPH_FWD = 1'b0,
    CIPH_INV = 1'b1
  } ciph_op_e;

  // Rcon start values loaded on clear
  localparam byte_t RconInitFwd    = 8'h01;
  localparam byte_t RconInitInv128 = 8'h36;
  localparam byte_t RconInitInv256 = 8'h40;

  // Multiply by x modulo x^8 + x^4 + x^3 + x + 1
  function automatic byte_t aes_mul2(byte_t in);
    byte_t out;
    out = {in[6:0], 1'b0};
    if (in[7]) begin
      out = out ^ 8'h1b;
    end
    return out;
  endfunction

  // Divide by x, the inverse of aes_mul2
  function automatic byte_t aes_div2(byte_t in);
    byte_t out;
    out = {in[0], in[7:1]};
    // Odd input means the reduction polynomial was folded in
    if (in[0]) begin
      out = out ^ 8'h0d;
    end
    return out;
  endfunction

  // RotWord moves byte 0 to the top
  function automatic word_t aes_rot_word(word_t in);
    return {in[0], in[3:1]};
  endfunction

endpackage

/* source/aes_key_word_combine.sv */
////////////////////
// Rcon register and the XOR chaining that forms the next round key
// key_o follows key_i and the S-box result combinationally
// Rcon advances once per completed handshake
////////////////////

`timescale 1ns/1ns

module aes_key_word_combine #(
  parameter bit AES256Enable = 1'b1
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  clear_i,
  input  aes_key_pkg::ciph_op_e op_i,
  input  aes_key_pkg::key_len_e key_len_i,
  input  aes_key_pkg::round_t   round_i,
  input  aes_key_pkg::key_t     key_i,
  input  aes_key_pkg::word_t    sub_word_i,
  input  logic            [3:0] sbox_req_i,
  input  logic                  out_ack_i,
  output aes_key_pkg::key_t     key_o,
  output logic                  out_req_o
);

  logic               is_256;
  logic               use_rcon;
  logic               rcon_we;
  aes_key_pkg::byte_t rcon_d;
  aes_key_pkg::byte_t rcon_q;
  aes_key_pkg::word_t irregular;
  aes_key_pkg::key_t  new_key;

  assign is_256 = AES256Enable && (key_len_i == aes_key_pkg::AES_256);

  // All four bytes must be ready
  assign out_req_o = &sbox_req_i;

  ////////////////////
  // Rcon
  ////////////////////

  // AES-256 even rounds skip Rcon
  assign use_rcon = !(is_256 && !round_i[0]);

  always_comb begin : rcon_update
    if (clear_i) begin
      if (op_i == aes_key_pkg::CIPH_FWD) begin
        rcon_d = aes_key_pkg::RconInitFwd;
      end else if (is_256) begin
        rcon_d = aes_key_pkg::RconInitInv256;
      end else begin
        rcon_d = aes_key_pkg::RconInitInv128;
      end
    end else if (op_i == aes_key_pkg::CIPH_FWD) begin
      rcon_d = aes_key_pkg::aes_mul2(rcon_q);
    end else begin
      rcon_d = aes_key_pkg::aes_div2(rcon_q);
    end
  end

  // Clear always wins; otherwise advance on a completing round
  assign rcon_we = clear_i | (use_rcon & out_req_o & out_ack_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin : reg_rcon
    if (!rst_ni) begin
      rcon_q <= '0;
    end else if (rcon_we) begin
      rcon_q <= rcon_d;
    end
  end

  // Rcon only touches byte 0 of the SubWord result
  assign irregular = use_rcon ? {sub_word_i[3:1], sub_word_i[0] ^ rcon_q} : sub_word_i;

  ////////////////////
  // Key chaining
  ////////////////////

  always_comb begin : form_key
    // Unused words fall back to the swapped halves of key_i
    new_key = {key_i[3:0], key_i[7:4]};
    if (!is_256) begin
      new_key[0]   = irregular ^ key_i[0];
      for (int i = 1; i < 4; i++) begin
        if (op_i == aes_key_pkg::CIPH_FWD) begin
          // Chain from word 0 upward
          new_key[i] = new_key[i-1] ^ key_i[i];
        end else begin
          new_key[i] = key_i[i-1] ^ key_i[i];
        end
      end
    end else if (round_i != '0) begin
      if (op_i == aes_key_pkg::CIPH_FWD) begin
        // Old upper half moves down
        new_key[3:0] = key_i[7:4];
        new_key[4]   = irregular ^ key_i[0];
        for (int i = 1; i < 4; i++) begin
          new_key[i+4] = new_key[i+3] ^ key_i[i];
        end
      end else begin
        // Old lower half moves up
        new_key[7:4] = key_i[3:0];
        new_key[0]   = irregular ^ key_i[4];
        for (int i = 0; i < 3; i++) begin
          new_key[i+1] = key_i[4+i] ^ key_i[5+i];
        end
      end
    end
  end

  assign key_o = new_key;

endmodule

/* source/aes_key_word_select.sv */
////////////////////
// Picks the word that enters SubWord and applies RotWord
// Purely combinational
// With AES256Enable at 0 every request is handled as AES-128
////////////////////

`timescale 1ns/1ns

module aes_key_word_select #(
  parameter bit AES256Enable = 1'b1
) (
  input  aes_key_pkg::key_len_e key_len_i,
  input  aes_key_pkg::ciph_op_e op_i,
  input  aes_key_pkg::round_t   round_i,
  input  aes_key_pkg::key_t     key_i,
  output aes_key_pkg::word_t    sub_word_o
);

  logic               is_256;
  logic               use_rot_word;
  aes_key_pkg::word_t spec_in_128;
  aes_key_pkg::word_t rot_word_in;
  aes_key_pkg::word_t rot_word_out;

  // Key length after applying the build option
  assign is_256 = AES256Enable && (key_len_i == aes_key_pkg::AES_256);

  // Previous word 3 for the AES-128 inverse direction
  assign spec_in_128 = key_i[3] ^ key_i[2];

  ////////////////////
  // Word selection
  ////////////////////

  always_comb begin : rot_word_in_mux
    if (is_256) begin
      // Forward reads the newest upper half
      if (op_i == aes_key_pkg::CIPH_FWD) begin
        rot_word_in = key_i[7];
      end else begin
        rot_word_in = key_i[3];
      end
    end else begin
      if (op_i == aes_key_pkg::CIPH_FWD) begin
        rot_word_in = key_i[3];
      end else begin
        rot_word_in = spec_in_128;
      end
    end
  end

  ////////////////////
  // RotWord
  ////////////////////

  // AES-256 even rounds feed SubWord without rotation
  assign use_rot_word = !(is_256 && !round_i[0]);

  assign rot_word_out = aes_key_pkg::aes_rot_word(rot_word_in);

  // Word handed to the four S-boxes
  assign sub_word_o = use_rot_word ? rot_word_out : rot_word_in;

endmodule

/* source/aes_sbox_lut.sv */
////////////////////
// Forward AES S-box for one byte, registered
// Result and request appear one cycle after the input is taken
// Both are frozen while the request waits for out_ack_i
////////////////////

`timescale 1ns/1ns

module aes_sbox_lut (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               en_i,
  input  logic               out_ack_i,
  input  aes_key_pkg::byte_t data_i,
  output aes_key_pkg::byte_t data_o,
  output logic               out_req_o
);

  // Forward substitution table indexed by the input byte
  localparam aes_key_pkg::byte_t SboxFwd [256] = '{
    8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
    8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
    8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
    8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
    8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
    8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
    8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
    8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
    8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
    8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
    8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
    8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
    8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
    8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
    8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
    8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
    8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
    8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
    8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
    8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
    8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
    8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
    8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
    8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
    8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
    8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
    8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
    8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
    8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
    8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
    8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
    8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
  };

  logic               hold;
  logic               req_q;
  aes_key_pkg::byte_t data_q;

  // Pending result not yet acknowledged
  assign hold = req_q & ~out_ack_i;

  ////////////////////
  // Request flag
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : reg_req
    if (!rst_ni) begin
      req_q <= 1'b0;
    end else if (!hold) begin
      req_q <= en_i;
    end
  end

  // Substituted byte, reloaded whenever nothing is held
  always_ff @(posedge clk_i) begin : reg_data
    if (!hold) begin
      data_q <= SboxFwd[data_i];
    end
  end

  assign data_o    = data_q;
  assign out_req_o = req_q;

endmodule

/* test/aes_key_expand_checker.sv */
////////////////////
// Watches the key expansion ports and compares every handshake
// Holds its own FIPS-197 schedule with an S-box from GF inverse and affine map
// AES-128 results are compared on words 3 to 0 only
////////////////////

`timescale 1ns/1ns

module aes_key_expand_checker (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  clear_i,
  input  logic                  en_i,
  input  logic                  ack_i,
  input  logic                  req_i,
  input  aes_key_pkg::ciph_op_e op_i,
  input  aes_key_pkg::key_len_e key_len_i,
  input  aes_key_pkg::key_t     key_in_i,
  input  aes_key_pkg::key_t     key_out_i,
  output int                    tests_done_o,
  output int                    tests_failed_o,
  output int                    errors_o
);

  logic [7:0]   sbox [256];
  logic [7:0]   rcon [11];
  // Expanded key words with w[0] as the cipher key's first word
  logic [31:0]  w [60];
  int           nk;
  int           total;
  int           steps;
  int           step;
  int           test_idx;
  int           test_errs;
  logic         active;
  logic         inv;
  logic         after_reset;
  logic         prev_en;
  logic         prev_req;
  logic         prev_ack;
  logic [255:0] prev_key;

  ////////////////////
  // GF(2^8) model
  ////////////////////

  function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] p;
    logic [7:0] x;
    p = 8'h00;
    x = a;
    for (int i = 0; i < 8; i++) begin
      if (b[i]) begin
        p = p ^ x;
      end
      // Shift by x and reduce by 0x11b
      x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
    end
    return p;
  endfunction

  // a^254 by square and multiply so that zero maps to zero
  function automatic logic [7:0] gf_inverse(input logic [7:0] a);
    logic [7:0] r;
    r = 8'h01;
    for (int i = 7; i >= 0; i--) begin
      r = gf_mul(r, r);
      if (i != 0) begin
        r = gf_mul(r, a);
      end
    end
    return r;
  endfunction

  function automatic logic [7:0] affine_map(input logic [7:0] b);
    return b ^ {b[6:0], b[7]} ^ {b[5:0], b[7:6]} ^ {b[4:0], b[7:5]} ^ {b[3:0], b[7:4]} ^ 8'h63;
  endfunction

  function automatic logic [31:0] sub_word(input logic [31:0] v);
    return {sbox[v[31:24]], sbox[v[23:16]], sbox[v[15:8]], sbox[v[7:0]]};
  endfunction

  // First byte sits in the low bits, so it moves to the top
  function automatic logic [31:0] rot_word(input logic [31:0] v);
    return {v[7:0], v[31:8]};
  endfunction

  // Term that w[i-nk] is XORed with to give w[i]
  function automatic logic [31:0] schedule_temp(input logic [31:0] prev, input int i);
    logic [31:0] t;
    t = prev;
    if (i % nk == 0) begin
      t = sub_word(rot_word(prev)) ^ {24'h000000, rcon[i / nk]};
    end else if (nk == 8 && i % 8 == 4) begin
      t = sub_word(prev);
    end
    return t;
  endfunction

  ////////////////////
  // Schedule handling
  ////////////////////

  task automatic report_fail(input string msg);
    $display("Fail %0t: %s", $time, msg);
    errors_o = errors_o + 1;
    test_errs = test_errs + 1;
  endtask

  // Forward starts from the cipher key and inverse from the last round key
  task automatic load_schedule;
    nk = (key_len_i == aes_key_pkg::AES_256) ? 8 : 4;
    total = (nk == 8) ? 60 : 44;
    steps = (nk == 8) ? 14 : 10;
    inv = (op_i == aes_key_pkg::CIPH_INV);
    if (!inv) begin
      for (int j = 0; j < nk; j++) begin
        // AES-256 loads the halves swapped
        w[j] = (nk == 8) ? key_in_i[(j + 4) % 8] : key_in_i[j];
      end
      for (int i = nk; i < total; i++) begin
        w[i] = w[i - nk] ^ schedule_temp(w[i - 1], i);
      end
    end else begin
      for (int j = 0; j < nk; j++) begin
        w[total - nk + j] = key_in_i[j];
      end
      // Solve the recurrence backward
      for (int i = total - 1; i >= nk; i--) begin
        w[i - nk] = w[i] ^ schedule_temp(w[i - 1], i);
      end
    end
    test_idx = test_idx + 1;
    step = 0;
    test_errs = 0;
    active = 1'b1;
  endtask

  // Expected key_o after handshake s of the schedule counting from 1
  function automatic logic [255:0] expected_key(input int s);
    logic [255:0] exp;
    int           base;
    exp = '0;
    if (nk == 4) begin
      base = inv ? 4 * (10 - s) : 4 * s;
      for (int j = 0; j < 4; j++) begin
        exp[32*j +: 32] = w[base + j];
      end
    end else if (inv && s == 14) begin
      // Round 0 going back restores the swapped load order
      for (int j = 0; j < 8; j++) begin
        exp[32*j +: 32] = w[(j + 4) % 8];
      end
    end else begin
      base = inv ? 4 * (13 - s) : 4 * (s - 1);
      for (int j = 0; j < 8; j++) begin
        exp[32*j +: 32] = w[base + j];
      end
    end
    return exp;
  endfunction

  task automatic check_round;
    logic [255:0] exp;
    logic [255:0] got;
    logic [255:0] mask;
    if (!active) begin
      report_fail("handshake outside a key schedule");
    end else begin
      step = step + 1;
      exp = expected_key(step);
      got = key_out_i;
      mask = (nk == 4) ? {{128{1'b0}}, {128{1'b1}}} : {256{1'b1}};
      if ((got & mask) !== exp) begin
        report_fail($sformatf("test %0d step %0d key_o %h, expected %h",
                              test_idx, step, got & mask, exp));
      end
      if (step == steps) begin
        $display("Test %0d: AES-%0d %s, %0d rounds, %s", test_idx, (nk == 8) ? 256 : 128,
                 inv ? "inverse" : "forward", steps, (test_errs == 0) ? "passed" : "failed");
        tests_done_o = tests_done_o + 1;
        if (test_errs != 0) begin
          tests_failed_o = tests_failed_o + 1;
        end
        active = 1'b0;
      end
    end
  endtask

  initial begin : build_tables
    for (int i = 0; i < 256; i++) begin
      sbox[i] = affine_map(gf_inverse(8'(i)));
    end
    rcon[0] = 8'h00;
    rcon[1] = 8'h01;
    for (int i = 2; i < 11; i++) begin
      rcon[i] = gf_mul(rcon[i - 1], 8'h02);
    end
    tests_done_o = 0;
    tests_failed_o = 0;
    errors_o = 0;
    test_idx = 0;
    test_errs = 0;
    active = 1'b0;
    after_reset = 1'b0;
  end

  ////////////////////
  // Port monitor
  ////////////////////

  // Values read here are the ones held during the cycle that just ended
  always @(posedge clk_i) begin : watch_ports
    if (!rst_ni) begin
      after_reset = 1'b1;
      active = 1'b0;
    end else begin
      if (after_reset) begin
        if (req_i !== 1'b0) begin
          report_fail("out_req_o not low after reset");
        end
        after_reset = 1'b0;
      end else if (prev_req && !prev_ack) begin
        // Back-pressure freezes request and key
        if (req_i !== 1'b1) begin
          report_fail("out_req_o dropped before out_ack_i");
        end else if (key_out_i !== prev_key) begin
          report_fail("key_o changed while waiting for out_ack_i");
        end
      end else if (req_i !== prev_en) begin
        report_fail("out_req_o did not follow en_i one cycle later");
      end
      if (clear_i) begin
        load_schedule();
      end else if (req_i && ack_i) begin
        check_round();
      end
      prev_en = en_i;
      prev_req = req_i;
      prev_ack = ack_i;
      prev_key = key_out_i;
    end
  end

endmodule

/* test/tb_aes_key_expand.sv */
////////////////////
// Testbench for the AES key expansion top level
// Runs NumTests schedules cycling through key length and direction
// The cycle starts at a random mode
// Inverse schedules continue from the key left by the previous one
////////////////////

`timescale 1ns/1ns

module tb_aes_key_expand;

  localparam int          NumTests  = 12;
  localparam int          ClkPeriod = 8;
  localparam logic [31:0] LfsrSeed  = 32'hee51_92d3;

  logic                  clk_i;
  logic                  rst_ni;
  logic                  clear_i;
  logic                  en_i;
  logic                  out_ack_i;
  aes_key_pkg::ciph_op_e op_i;
  aes_key_pkg::key_len_e key_len_i;
  aes_key_pkg::round_t   round_i;
  aes_key_pkg::key_t     key_i;
  aes_key_pkg::key_t     key_o;
  logic                  out_req_o;
  logic [31:0]           lfsr_state;
  logic [255:0]          init_bits;
  logic [255:0]          mode_bits;
  int                    mode_base;
  int                    tests_done;
  int                    tests_failed;
  int                    error_count;

  aes_key_expand_top #(
    .AES256Enable ( 1'b1 )
  ) dut0 (
    .clk_i     ( clk_i     ),
    .rst_ni    ( rst_ni    ),
    .clear_i   ( clear_i   ),
    .en_i      ( en_i      ),
    .out_ack_i ( out_ack_i ),
    .op_i      ( op_i      ),
    .key_len_i ( key_len_i ),
    .round_i   ( round_i   ),
    .key_i     ( key_i     ),
    .key_o     ( key_o     ),
    .out_req_o ( out_req_o )
  );

  aes_key_expand_checker u_checker (
    .clk_i          ( clk_i        ),
    .rst_ni         ( rst_ni       ),
    .clear_i        ( clear_i      ),
    .en_i           ( en_i         ),
    .ack_i          ( out_ack_i    ),
    .req_i          ( out_req_o    ),
    .op_i           ( op_i         ),
    .key_len_i      ( key_len_i    ),
    .key_in_i       ( key_i        ),
    .key_out_i      ( key_o        ),
    .tests_done_o   ( tests_done   ),
    .tests_failed_o ( tests_failed ),
    .errors_o       ( error_count  )
  );

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
  endfunction

  // One LFSR step per bit
  task automatic take_bits(input int count, output logic [255:0] value);
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      value[i] = lfsr_state[0];
    end
  endtask

  // One handshake with a random acknowledge delay of 0 to 3 cycles
  task automatic run_round(input aes_key_pkg::round_t rnd);
    logic [255:0] delay_bits;
    int           delay;
    take_bits(2, delay_bits);
    delay = int'(delay_bits[1:0]);
    @(posedge clk_i);
    round_i <= rnd;
    en_i <= 1'b1;
    do begin
      @(posedge clk_i);
    end while (!out_req_o);
    repeat (delay) @(posedge clk_i);
    out_ack_i <= 1'b1;
    en_i <= 1'b0;
    // Handshake completes here and the result goes back in
    @(posedge clk_i);
    out_ack_i <= 1'b0;
    key_i <= key_o;
  endtask

  // Bit 0 of the mode selects AES-256 and bit 1 the inverse direction
  task automatic run_schedule(input int mode);
    logic [255:0] bits;
    logic         is_256;
    logic         is_inv;
    int           rounds;
    is_256 = mode[0];
    is_inv = mode[1];
    rounds = is_256 ? 14 : 10;
    @(posedge clk_i);
    if (is_256) begin
      key_len_i <= aes_key_pkg::AES_256;
    end else begin
      key_len_i <= aes_key_pkg::AES_128;
    end
    if (is_inv) begin
      op_i <= aes_key_pkg::CIPH_INV;
    end else begin
      op_i <= aes_key_pkg::CIPH_FWD;
      take_bits(256, bits);
      key_i <= bits;
    end
    clear_i <= 1'b1;
    @(posedge clk_i);
    clear_i <= 1'b0;
    // AES-256 counts 0..13 and AES-128 counts 1..10
    for (int k = 0; k < rounds; k++) begin
      if (is_256) begin
        run_round(aes_key_pkg::round_t'(is_inv ? 13 - k : k));
      end else begin
        run_round(aes_key_pkg::round_t'(is_inv ? 10 - k : k + 1));
      end
    end
  endtask

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  initial begin : main_sequence
    lfsr_state = LfsrSeed;
    take_bits(256, init_bits);
    take_bits(2, mode_bits);
    mode_base = int'(mode_bits[1:0]);
    rst_ni = 1'b0;
    clear_i = 1'b0;
    en_i = 1'b0;
    out_ack_i = 1'b0;
    op_i = aes_key_pkg::CIPH_FWD;
    key_len_i = aes_key_pkg::AES_128;
    round_i = '0;
    key_i = init_bits;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    for (int t = 0; t < NumTests; t++) begin
      run_schedule((mode_base + t) % 4);
    end
    repeat (4) @(posedge clk_i);
    $display("Done: %0d of %0d tests run, %0d failed, %0d errors",
             tests_done, NumTests, tests_failed, error_count);
    if (error_count == 0 && tests_failed == 0 && tests_done == NumTests) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // Budget of 14 rounds of 10 cycles per test
  initial begin : watchdog
    #(NumTests * 14 * 10 * ClkPeriod);
    $display("Timeout: out_req_o never came, run stopped at %0t", $time);
    $display("Simulation FAILED");
    $finish;
  end

endmodule
